// ==== src/dpq_pkg.sv ====
package dpq_pkg;

  // which end of the queue a dequeue request takes from
  typedef enum logic {
    DEQ_SMALLEST = 1'b0,
    DEQ_LARGEST  = 1'b1
  } deq_kind_e;

  // payload width, e.g. a point index
  parameter int DEF_DATA_WIDTH = 16;

  // tag width, e.g. a distance
  parameter int DEF_TAG_WIDTH = 16;

  // number of storage slots
  parameter int DEF_DEPTH = 8;

  // pending dequeue requests held while a rescan runs
  parameter int DEF_REQ_DEPTH = 4;

endpackage

// ==== src/deq_request_buffer.sv ====
`timescale 1ns/1ns

module deq_request_buffer #(
  parameter int REQ_DEPTH = 4
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                push_smallest,
  input  logic                push_largest,
  input  logic                req_take,
  output dpq_pkg::deq_kind_e  req_kind,
  output logic                req_pending
);

  localparam int PTR_W = $clog2(REQ_DEPTH);
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  dpq_pkg::deq_kind_e kinds [REQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic do_push;
  logic do_pop;

  // smallest wins when both pulses arrive together
  assign push    = push_smallest | push_largest;
  assign do_push = push && (count != CNT_W'(REQ_DEPTH));
  assign do_pop  = req_take && (count != '0);

  assign req_pending = (count != '0);
  assign req_kind    = kinds[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      kinds[wr_ptr] <= push_smallest ? dpq_pkg::DEQ_SMALLEST : dpq_pkg::DEQ_LARGEST;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/slot_allocator.sv ====
`timescale 1ns/1ns

module slot_allocator #(
  parameter int DEPTH = 8
) (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     slot_claim,
  input  logic                     slot_release,
  input  logic [$clog2(DEPTH)-1:0] released_slot,
  output logic [$clog2(DEPTH)-1:0] free_slot
);

  localparam int SLOT_W = $clog2(DEPTH);

  // ring of free slot indices, oldest free slot at the head
  logic [SLOT_W-1:0] ring [DEPTH];

  logic [SLOT_W-1:0] head;
  logic [SLOT_W-1:0] tail;

  assign free_slot = ring[head];

  // the ring starts full, so tail begins on top of head
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < DEPTH; i++) begin
        ring[i] <= SLOT_W'(i);
      end
    end else if (slot_release) begin
      ring[tail] <= released_slot;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (slot_claim) begin
        head <= (head == SLOT_W'(DEPTH - 1)) ? '0 : head + 1'b1;
      end
      if (slot_release) begin
        tail <= (tail == SLOT_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
      end
    end
  end

  // claim and release in one cycle touch different ring entries
  // because a released slot was occupied, so the ring is not full

endmodule

// ==== src/extreme_tracker.sv ====
`timescale 1ns/1ns

module extreme_tracker #(
  parameter int TAG_WIDTH = 16,
  parameter int DEPTH     = 8
) (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     enq_write,
  input  logic [$clog2(DEPTH)-1:0] enq_slot,
  input  logic [TAG_WIDTH-1:0]     enq_tag,
  input  logic                     removed,
  input  logic [TAG_WIDTH-1:0]     scan_tag,
  input  logic                     scan_valid,
  output logic [$clog2(DEPTH)-1:0] scan_slot,
  output logic                     scan_busy,
  output logic [$clog2(DEPTH)-1:0] min_slot,
  output logic [$clog2(DEPTH)-1:0] max_slot,
  output logic [TAG_WIDTH-1:0]     min_tag,
  output logic [TAG_WIDTH-1:0]     max_tag
);

  localparam int SLOT_W = $clog2(DEPTH);

  logic scanning;

  logic [TAG_WIDTH-1:0] min_tag_nxt;
  logic [TAG_WIDTH-1:0] max_tag_nxt;
  logic [SLOT_W-1:0]    min_slot_nxt;
  logic [SLOT_W-1:0]    max_slot_nxt;

  // removed covers the cycle before the walk starts
  assign scan_busy = scanning | removed;

  // fold order: sentinel restart or scanned slot first, then the new entry
  always_comb begin
    min_tag_nxt  = min_tag;
    max_tag_nxt  = max_tag;
    min_slot_nxt = min_slot;
    max_slot_nxt = max_slot;

    if (removed) begin
      min_tag_nxt  = '1;
      max_tag_nxt  = '0;
      min_slot_nxt = '0;
      max_slot_nxt = '0;
    end else if (scanning && scan_valid) begin
      if (scan_tag <= min_tag_nxt) begin
        min_tag_nxt  = scan_tag;
        min_slot_nxt = scan_slot;
      end
      if (scan_tag >= max_tag_nxt) begin
        max_tag_nxt  = scan_tag;
        max_slot_nxt = scan_slot;
      end
    end

    // an entry written mid-scan may sit in a slot already visited
    if (enq_write) begin
      if (enq_tag <= min_tag_nxt) begin
        min_tag_nxt  = enq_tag;
        min_slot_nxt = enq_slot;
      end
      if (enq_tag >= max_tag_nxt) begin
        max_tag_nxt  = enq_tag;
        max_slot_nxt = enq_slot;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      min_tag  <= '1;
      max_tag  <= '0;
      min_slot <= '0;
      max_slot <= '0;
    end else begin
      min_tag  <= min_tag_nxt;
      max_tag  <= max_tag_nxt;
      min_slot <= min_slot_nxt;
      max_slot <= max_slot_nxt;
    end
  end

  // walk every slot once, DEPTH cycles
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      scanning  <= 1'b0;
      scan_slot <= '0;
    end else if (removed) begin
      scanning  <= 1'b1;
      scan_slot <= '0;
    end else if (scanning) begin
      if (scan_slot == SLOT_W'(DEPTH - 1)) begin
        scanning  <= 1'b0;
        scan_slot <= '0;
      end else begin
        scan_slot <= scan_slot + 1'b1;
      end
    end
  end

endmodule

// ==== src/slot_store.sv ====
`timescale 1ns/1ns

module slot_store #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 16,
  parameter int DEPTH      = 8
) (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     enq_in,
  input  logic [DATA_WIDTH-1:0]    enq_data_in,
  input  logic [TAG_WIDTH-1:0]     enq_tag_in,
  input  dpq_pkg::deq_kind_e       req_kind,
  input  logic                     req_pending,
  input  logic                     scan_busy,
  input  logic [$clog2(DEPTH)-1:0] free_slot,
  input  logic [$clog2(DEPTH)-1:0] min_slot,
  input  logic [$clog2(DEPTH)-1:0] max_slot,
  input  logic [$clog2(DEPTH)-1:0] scan_slot,
  output logic                     req_take,
  output logic                     slot_claim,
  output logic                     slot_release,
  output logic [$clog2(DEPTH)-1:0] released_slot,
  output logic                     enq_write,
  output logic [$clog2(DEPTH)-1:0] enq_slot,
  output logic [TAG_WIDTH-1:0]     enq_tag,
  output logic                     removed,
  output logic [TAG_WIDTH-1:0]     scan_tag,
  output logic                     scan_valid,
  output logic [DATA_WIDTH-1:0]    data_out,
  output logic [TAG_WIDTH-1:0]     tag_out,
  output logic                     valid_out,
  output logic [$clog2(DEPTH):0]   size_out,
  output logic                     full_out,
  output logic                     empty_out
);

  localparam int SLOT_W = $clog2(DEPTH);
  localparam int SIZE_W = SLOT_W + 1;

  logic [TAG_WIDTH-1:0]  tags     [DEPTH];
  logic [DATA_WIDTH-1:0] payloads [DEPTH];
  logic [DEPTH-1:0]      valid;

  logic              enq_accept;
  logic              do_remove;
  logic [SLOT_W-1:0] rem_slot;

  assign full_out  = (size_out == SIZE_W'(DEPTH));
  assign empty_out = (size_out == '0);

  assign enq_accept = enq_in && !full_out;

  // a popped request on an empty queue is simply dropped
  assign req_take  = req_pending && !scan_busy;
  assign do_remove = req_take && !empty_out;
  assign rem_slot  = (req_kind == dpq_pkg::DEQ_SMALLEST) ? min_slot : max_slot;

  assign slot_claim    = enq_accept;
  assign slot_release  = do_remove;
  assign released_slot = rem_slot;

  assign enq_write = enq_accept;
  assign enq_slot  = free_slot;
  assign enq_tag   = enq_tag_in;

  // read port for the tracker's rescan
  assign scan_tag   = tags[scan_slot];
  assign scan_valid = valid[scan_slot];

  always_ff @(posedge clk_in) begin
    if (enq_accept) begin
      tags[free_slot]     <= enq_tag_in;
      payloads[free_slot] <= enq_data_in;
    end
    if (do_remove) begin
      data_out <= payloads[rem_slot];
      tag_out  <= tags[rem_slot];
    end
  end

  // free and removed slots always differ, so both writes can land together
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid     <= '0;
      valid_out <= 1'b0;
      removed   <= 1'b0;
      size_out  <= '0;
    end else begin
      if (enq_accept) begin
        valid[free_slot] <= 1'b1;
      end
      if (do_remove) begin
        valid[rem_slot] <= 1'b0;
      end
      valid_out <= do_remove;
      removed   <= do_remove;
      case ({enq_accept, do_remove})
        2'b10:   size_out <= size_out + 1'b1;
        2'b01:   size_out <= size_out - 1'b1;
        default: size_out <= size_out;
      endcase
    end
  end

endmodule

// ==== src/checked_queue.sv ====
`timescale 1ns/1ns

module checked_queue #(
  parameter int DATA_WIDTH = dpq_pkg::DEF_DATA_WIDTH,
  parameter int TAG_WIDTH  = dpq_pkg::DEF_TAG_WIDTH,
  parameter int DEPTH      = dpq_pkg::DEF_DEPTH,
  parameter int REQ_DEPTH  = dpq_pkg::DEF_REQ_DEPTH
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   enq_in,
  input  logic [DATA_WIDTH-1:0]  enq_data_in,
  input  logic [TAG_WIDTH-1:0]   enq_tag_in,
  input  logic                   deq_smallest_in,
  input  logic                   deq_largest_in,
  output logic [DATA_WIDTH-1:0]  data_out,
  output logic [TAG_WIDTH-1:0]   tag_out,
  output logic                   valid_out,
  output logic [$clog2(DEPTH):0] size_out,
  output logic                   full_out,
  output logic                   empty_out,
  output logic [TAG_WIDTH-1:0]   min_tag_out,
  output logic [TAG_WIDTH-1:0]   max_tag_out,
  output logic                   busy_out
);

  localparam int SLOT_W = $clog2(DEPTH);

  dpq_pkg::deq_kind_e   req_kind;
  logic                 req_pending;
  logic                 req_take;
  logic                 slot_claim;
  logic                 slot_release;
  logic [SLOT_W-1:0]    released_slot;
  logic [SLOT_W-1:0]    free_slot;
  logic                 enq_write;
  logic [SLOT_W-1:0]    enq_slot;
  logic [TAG_WIDTH-1:0] enq_tag;
  logic                 removed;
  logic [SLOT_W-1:0]    scan_slot;
  logic [TAG_WIDTH-1:0] scan_tag;
  logic                 scan_valid;
  logic [SLOT_W-1:0]    min_slot;
  logic [SLOT_W-1:0]    max_slot;

  deq_request_buffer #(.REQ_DEPTH(REQ_DEPTH)) req_buf0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .push_smallest(deq_smallest_in), .push_largest(deq_largest_in),
    .req_take(req_take), .req_kind(req_kind), .req_pending(req_pending)
  );

  slot_allocator #(.DEPTH(DEPTH)) alloc0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .slot_claim(slot_claim), .slot_release(slot_release),
    .released_slot(released_slot), .free_slot(free_slot)
  );

  extreme_tracker #(.TAG_WIDTH(TAG_WIDTH), .DEPTH(DEPTH)) tracker0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .enq_write(enq_write), .enq_slot(enq_slot), .enq_tag(enq_tag),
    .removed(removed), .scan_tag(scan_tag), .scan_valid(scan_valid),
    .scan_slot(scan_slot), .scan_busy(busy_out),
    .min_slot(min_slot), .max_slot(max_slot),
    .min_tag(min_tag_out), .max_tag(max_tag_out)
  );

  slot_store #(.DATA_WIDTH(DATA_WIDTH), .TAG_WIDTH(TAG_WIDTH), .DEPTH(DEPTH)) store0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .enq_in(enq_in), .enq_data_in(enq_data_in), .enq_tag_in(enq_tag_in),
    .req_kind(req_kind), .req_pending(req_pending), .scan_busy(busy_out),
    .free_slot(free_slot), .min_slot(min_slot), .max_slot(max_slot),
    .scan_slot(scan_slot), .req_take(req_take),
    .slot_claim(slot_claim), .slot_release(slot_release),
    .released_slot(released_slot),
    .enq_write(enq_write), .enq_slot(enq_slot), .enq_tag(enq_tag),
    .removed(removed), .scan_tag(scan_tag), .scan_valid(scan_valid),
    .data_out(data_out), .tag_out(tag_out), .valid_out(valid_out),
    .size_out(size_out), .full_out(full_out), .empty_out(empty_out)
  );

endmodule

// ==== test/checked_queue_assert.sv ====
`timescale 1ns/1ns

module checked_queue_assert #(
  parameter int DEPTH = 8
) (
  input logic                   clk_in,
  input logic                   rst_in,
  input logic                   valid_out,
  input logic                   full_out,
  input logic                   empty_out,
  input logic                   busy_out,
  input logic [$clog2(DEPTH):0] size_out
);

  // busy cycles seen before the current one
  int busy_run;

  always_ff @(posedge clk_in) begin
    if (rst_in || !busy_out) begin
      busy_run <= 0;
    end else begin
      busy_run <= busy_run + 1;
    end
  end

  // the queue only empties through a removal
  empty_by_removal: assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(empty_out) |-> valid_out)
    else $error("empty_out rose without a removal on valid_out");

  // a full queue only drops below full through a removal
  full_left_by_removal: assert property (@(posedge clk_in) disable iff (rst_in)
    $fell(full_out) |-> valid_out)
    else $error("full_out fell without a removal on valid_out");

  size_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
    size_out <= DEPTH)
    else $error("size_out exceeds the queue depth");

  busy_bounded: assert property (@(posedge clk_in) disable iff (rst_in)
    busy_out |-> busy_run <= DEPTH)
    else $error("busy_out stayed high longer than DEPTH+1 cycles");

endmodule

bind checked_queue checked_queue_assert #(.DEPTH(DEPTH)) assert0 (
  .clk_in(clk_in), .rst_in(rst_in), .valid_out(valid_out),
  .full_out(full_out), .empty_out(empty_out), .busy_out(busy_out),
  .size_out(size_out)
);

// ==== test/checked_queue_tb.sv ====
`timescale 1ns/1ns

module checked_queue_tb;

  localparam int DW    = dpq_pkg::DEF_DATA_WIDTH;
  localparam int TW    = dpq_pkg::DEF_TAG_WIDTH;
  localparam int DEPTH = dpq_pkg::DEF_DEPTH;
  localparam int SW    = $clog2(DEPTH) + 1;

  typedef enum logic [1:0] {OP_ENQ, OP_DEQ, OP_WAIT} op_e;

  typedef struct packed {
    op_e                op;
    dpq_pkg::deq_kind_e kind;
    logic [DW-1:0]      data;
    logic [TW-1:0]      tag;
  } row_t;

  logic          clk_in;
  logic          rst_in;
  logic          enq_in;
  logic [DW-1:0] enq_data_in;
  logic [TW-1:0] enq_tag_in;
  logic          deq_smallest_in;
  logic          deq_largest_in;
  logic [DW-1:0] data_out;
  logic [TW-1:0] tag_out;
  logic          valid_out;
  logic [SW-1:0] size_out;
  logic          full_out;
  logic          empty_out;
  logic [TW-1:0] min_tag_out;
  logic [TW-1:0] max_tag_out;
  logic          busy_out;

  row_t rows [$];

  // reference model, keyed by tag so first and last give the extremes
  logic [DW-1:0]      model [logic [TW-1:0]];
  dpq_pkg::deq_kind_e pending [$];
  logic [DW-1:0]      exp_data_q [$];
  logic [TW-1:0]      exp_tag_q [$];
  int                 busy_cnt;
  logic               exp_valid;

  integer seed;
  int     errors;
  int     checks;
  int     limit;
  int     cycles = 0;

  checked_queue dut0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .enq_in(enq_in), .enq_data_in(enq_data_in), .enq_tag_in(enq_tag_in),
    .deq_smallest_in(deq_smallest_in), .deq_largest_in(deq_largest_in),
    .data_out(data_out), .tag_out(tag_out), .valid_out(valid_out),
    .size_out(size_out), .full_out(full_out), .empty_out(empty_out),
    .min_tag_out(min_tag_out), .max_tag_out(max_tag_out), .busy_out(busy_out)
  );

  always #20 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic cmp_data(input string name, input logic [DW-1:0] got,
                          input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic cmp_tag(input string name, input logic [TW-1:0] got,
                         input logic [TW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic cmp_size(input string name, input logic [SW-1:0] got,
                          input logic [SW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic cmp_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_row(input op_e op, input dpq_pkg::deq_kind_e kind,
                         input logic [DW-1:0] data, input logic [TW-1:0] tag);
    rows.push_back(row_t'{op, kind, data, tag});
  endtask

  task automatic build_table();
    // fill to full, then one enqueue that must be ignored
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a01, 16'h0300);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a02, 16'h0120);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a03, 16'h0a00);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a04, 16'h0050);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a05, 16'h0777);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a06, 16'h0200);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a07, 16'h0999);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0a08, 16'h0010);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'hdead, 16'h0001);
    add_row(OP_DEQ, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_DEQ, dpq_pkg::DEQ_LARGEST, '0, '0);
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
    // back to back requests with enqueues landing mid-scan
    add_row(OP_DEQ, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_DEQ, dpq_pkg::DEQ_LARGEST, '0, '0);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0b01, 16'h0005);
    add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, 16'h0b02, 16'h0fff);
    add_row(OP_DEQ, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_DEQ, dpq_pkg::DEQ_LARGEST, '0, '0);
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
    // drain, then a request on the empty queue
    for (int i = 0; i < 4; i++) begin
      add_row(OP_DEQ, i[0] ? dpq_pkg::DEQ_LARGEST : dpq_pkg::DEQ_SMALLEST, '0, '0);
    end
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_DEQ, dpq_pkg::DEQ_SMALLEST, '0, '0);
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
    // refill with random payloads so freed slots get reused
    for (int i = 0; i < DEPTH + 1; i++) begin
      add_row(OP_ENQ, dpq_pkg::DEQ_SMALLEST, DW'($random(seed)), TW'(16'h2000 + i * 16'h0137));
    end
    for (int i = 0; i < DEPTH + 1; i++) begin
      add_row(OP_DEQ, i[0] ? dpq_pkg::DEQ_SMALLEST : dpq_pkg::DEQ_LARGEST, '0, '0);
    end
    add_row(OP_WAIT, dpq_pkg::DEQ_SMALLEST, '0, '0);
  endtask

  task automatic check_outputs();
    logic [TW-1:0] k;
    logic [TW-1:0] exp_min;
    logic [TW-1:0] exp_max;
    exp_min = '1;
    exp_max = '0;
    if (model.first(k) != 0) exp_min = k;
    if (model.last(k) != 0) exp_max = k;
    cmp_size("size_out", size_out, SW'(model.num()));
    cmp_flag("empty_out", empty_out, model.num() == 0);
    cmp_flag("full_out", full_out, model.num() == DEPTH);
    cmp_flag("busy_out", busy_out, busy_cnt != 0);
    cmp_flag("valid_out", valid_out, exp_valid);
    if (valid_out && exp_valid) begin
      cmp_data("data_out", data_out, exp_data_q.pop_front());
      cmp_tag("tag_out", tag_out, exp_tag_q.pop_front());
    end
    // running extremes are only final outside a rescan
    if (busy_cnt == 0) begin
      cmp_tag("min_tag_out", min_tag_out, exp_min);
      cmp_tag("max_tag_out", max_tag_out, exp_max);
    end
  endtask

  // one clock cycle of the queue rules, applied to the inputs just driven
  task automatic update_model(input logic enq, input logic deq,
                              input dpq_pkg::deq_kind_e kind,
                              input logic [DW-1:0] data, input logic [TW-1:0] tag);
    logic               was_full;
    logic [TW-1:0]      k;
    dpq_pkg::deq_kind_e take_kind;
    was_full  = (model.num() == DEPTH);
    exp_valid = 1'b0;
    if (busy_cnt != 0) begin
      busy_cnt--;
    end else if (pending.size() != 0) begin
      take_kind = pending.pop_front();
      if (model.num() != 0) begin
        if (take_kind == dpq_pkg::DEQ_SMALLEST) begin
          void'(model.first(k));
        end else begin
          void'(model.last(k));
        end
        exp_data_q.push_back(model[k]);
        exp_tag_q.push_back(k);
        model.delete(k);
        exp_valid = 1'b1;
        busy_cnt  = DEPTH + 1;
      end
    end
    if (enq && !was_full) model[tag] = data;
    if (deq) pending.push_back(kind);
  endtask

  task automatic run_cycle(input logic enq, input logic deq, input dpq_pkg::deq_kind_e kind,
                           input logic [DW-1:0] data, input logic [TW-1:0] tag);
    @(posedge clk_in);
    #2;
    check_outputs();
    enq_in          = enq;
    enq_data_in     = data;
    enq_tag_in      = tag;
    deq_smallest_in = deq && (kind == dpq_pkg::DEQ_SMALLEST);
    deq_largest_in  = deq && (kind == dpq_pkg::DEQ_LARGEST);
    update_model(enq, deq, kind, data, tag);
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, 1'b0, dpq_pkg::DEQ_SMALLEST, '0, '0);
  endtask

  initial begin
    clk_in          = 1'b0;
    rst_in          = 1'b1;
    enq_in          = 1'b0;
    enq_data_in     = '0;
    enq_tag_in      = '0;
    deq_smallest_in = 1'b0;
    deq_largest_in  = 1'b0;
    seed      = 32'h7727_34bb;
    errors    = 0;
    checks    = 0;
    busy_cnt  = 0;
    exp_valid = 1'b0;
    build_table();
    limit = rows.size() * (dpq_pkg::DEF_DEPTH + 6);
    repeat (3) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    check_outputs();
    foreach (rows[i]) begin
      case (rows[i].op)
        OP_ENQ: run_cycle(1'b1, 1'b0, rows[i].kind, rows[i].data, rows[i].tag);
        OP_DEQ: begin
          while (busy_out) idle_cycle();
          run_cycle(1'b0, 1'b1, rows[i].kind, '0, '0);
        end
        default: begin
          idle_cycle();
          while (busy_out || pending.size() != 0) idle_cycle();
        end
      endcase
    end
    idle_cycle();
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("some expected removals never showed up on valid_out");
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== checked_queue.f ====
src/dpq_pkg.sv
src/deq_request_buffer.sv
src/slot_allocator.sv
src/extreme_tracker.sv
src/slot_store.sv
src/checked_queue.sv
test/checked_queue_assert.sv
test/checked_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the checked queue testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module checked_queue_tb \
  -f checked_queue.f -Mdir obj_dir > build.log 2>&1 &&
  ./obj_dir/Vchecked_queue_tb > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
